/* flist.f */
+incdir+hw
hw/sig_unit_pkg.sv
hw/sig_register_file.sv
hw/sig_alu.sv
hw/sig_microcode_rom.sv
hw/sig_sequencer.sv
hw/sig_unit_top.sv
verif/sig_unit_tb.sv

/* Bender.yml */
package:
  name: sig_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/sig_unit_pkg.sv
      - hw/sig_register_file.sv
      - hw/sig_alu.sv
      - hw/sig_microcode_rom.sv
      - hw/sig_sequencer.sv
      - hw/sig_unit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/sig_unit_tb.sv

/* verif/sig_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module sig_unit_tb;

	localparam int NUM_FIXED      = 10;
	localparam int NUM_RANDOM     = 8;
	localparam int NUM_TESTS      = NUM_FIXED + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 48;
	localparam sig_unit_pkg::sig_word_t ULP = 32'd128; // rounding constant

	logic                    clk_in = 1'b0;
	logic                    reset_in;
	logic                    start;
	sig_unit_pkg::sig_op_t   op;
	sig_unit_pkg::sig_word_t operand_a;
	sig_unit_pkg::sig_word_t operand_b;
	logic                    done;
	sig_unit_pkg::sig_word_t result;
	sig_unit_pkg::sig_word_t shift_count;

	// stimulus and expected values per test
	sig_unit_pkg::sig_op_t   tab_op      [NUM_TESTS];
	sig_unit_pkg::sig_word_t tab_a       [NUM_TESTS];
	sig_unit_pkg::sig_word_t tab_b       [NUM_TESTS];
	sig_unit_pkg::sig_word_t tab_res     [NUM_TESTS];
	sig_unit_pkg::sig_word_t tab_cnt     [NUM_TESTS];
	logic                    tab_chk_cnt [NUM_TESTS];

	integer seed;
	int     cycles = 0;
	int     errors;
	int     failed_tests;
	int     test_errors;
	int     cur_test;

	sig_unit_top sig_unit_top_i (
		.clk_in(clk_in), .reset_in(reset_in), .start(start), .op(op),
		.operand_a(operand_a), .operand_b(operand_b),
		.done(done), .result(result), .shift_count(shift_count)
	);

	always #10 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, done never arrived in test %0d",
				cycles, cur_test);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic string op_name(input sig_unit_pkg::sig_op_t code);
		case (code)
			sig_unit_pkg::OP_ADD:  return "add";
			sig_unit_pkg::OP_SUB:  return "sub";
			sig_unit_pkg::OP_NORM: return "norm";
			default:               return "round";
		endcase
	endfunction

	function automatic int lead_zeros(input sig_unit_pkg::sig_word_t value);
		int count;
		count = 0;
		for (int i = 31; i >= 0; i--) begin
			if (value[i]) break;
			count++;
		end
		return count;
	endfunction

	// reference model of the four operations
	function automatic sig_unit_pkg::sig_word_t expected_result(
		input sig_unit_pkg::sig_op_t code,
		input sig_unit_pkg::sig_word_t a,
		input sig_unit_pkg::sig_word_t b
	);
		case (code)
			sig_unit_pkg::OP_ADD:   return a + b;
			sig_unit_pkg::OP_SUB:   return a - b;
			sig_unit_pkg::OP_ROUND: return a + ULP;
			default:                return (a == '0) ? '0 : (a << lead_zeros(a));
		endcase
	endfunction

	function automatic sig_unit_pkg::sig_word_t expected_count(
		input sig_unit_pkg::sig_op_t code,
		input sig_unit_pkg::sig_word_t a,
		input sig_unit_pkg::sig_word_t b
	);
		if (code == sig_unit_pkg::OP_NORM) begin
			return (a == '0) ? '0 : lead_zeros(a);
		end
		return b; // add and sub leave b in r1
	endfunction

	task automatic set_entry(input int idx, input sig_unit_pkg::sig_op_t code,
			input sig_unit_pkg::sig_word_t a, input sig_unit_pkg::sig_word_t b,
			input sig_unit_pkg::sig_word_t res, input sig_unit_pkg::sig_word_t cnt,
			input logic chk);
		tab_op[idx]      = code;
		tab_a[idx]       = a;
		tab_b[idx]       = b;
		tab_res[idx]     = res;
		tab_cnt[idx]     = cnt;
		tab_chk_cnt[idx] = chk;
	endtask

	task automatic fill_table();
		sig_unit_pkg::sig_op_t   r_op;
		sig_unit_pkg::sig_word_t r_a;
		sig_unit_pkg::sig_word_t r_b;
		logic [31:0]             shift;
		set_entry(0, sig_unit_pkg::OP_ADD, 32'h1234, 32'h567, 32'h179b, 32'h567, 1);
		set_entry(1, sig_unit_pkg::OP_ADD, 32'hffffff00, 32'h200, 32'h100, 32'h200, 1);
		set_entry(2, sig_unit_pkg::OP_SUB, 32'h5000, 32'h1234, 32'h3dcc, 32'h1234, 1);
		set_entry(3, sig_unit_pkg::OP_SUB, 32'h10, 32'h20, 32'hfffffff0, 32'h20, 1);
		set_entry(4, sig_unit_pkg::OP_ROUND, 32'h12345, 32'h0, 32'h123c5, 32'h0, 0);
		set_entry(5, sig_unit_pkg::OP_ROUND, 32'hffffffc0, 32'h0, 32'h40, 32'h0, 0);
		set_entry(6, sig_unit_pkg::OP_NORM, 32'h80000001, 32'h0, 32'h80000001, 32'd0, 1);
		set_entry(7, sig_unit_pkg::OP_NORM, 32'h1, 32'h0, 32'h80000000, 32'd31, 1);
		set_entry(8, sig_unit_pkg::OP_NORM, 32'h0, 32'h0, 32'h0, 32'd0, 1);
		set_entry(9, sig_unit_pkg::OP_NORM, 32'h00f00000, 32'h0, 32'hf0000000, 32'd8, 1);
		for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
			r_op  = sig_unit_pkg::sig_op_t'(i % 4);
			r_a   = $random(seed);
			r_b   = $random(seed);
			shift = $random(seed);
			if (r_op == sig_unit_pkg::OP_NORM) begin
				r_a = r_a >> shift[4:0]; // spread the leading zero counts
			end
			set_entry(i, r_op, r_a, r_b, expected_result(r_op, r_a, r_b),
				expected_count(r_op, r_a, r_b), r_op != sig_unit_pkg::OP_ROUND);
		end
	endtask

	task automatic check_word(input string name, input sig_unit_pkg::sig_word_t got,
			input sig_unit_pkg::sig_word_t expected);
		assert (got === expected) else begin
			$display("FAIL test %0d: %s = %h, expected %h", cur_test, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		assert (got === expected) else begin
			$display("FAIL test %0d: %s = %h, expected %h", cur_test, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic wait_done();
		@(negedge clk_in);
		while (done !== 1'b1) begin
			@(negedge clk_in);
		end
	endtask

	task automatic run_entry(input int idx);
		test_errors = 0;
		cur_test    = idx;
		@(posedge clk_in);
		#2;
		start     = 1'b1;
		op        = tab_op[idx];
		operand_a = tab_a[idx];
		operand_b = tab_b[idx];
		@(posedge clk_in);
		#2;
		start = 1'b0;
		if (idx % 2 == 1) begin
			// extra start while busy with another op
			start = 1'b1;
			op    = tab_op[idx] + 2'd1;
			@(posedge clk_in);
			#2;
			start = 1'b0;
			op    = tab_op[idx];
		end
		wait_done();
		check_word("result", result, tab_res[idx]);
		if (tab_chk_cnt[idx]) begin
			check_word("shift_count", shift_count, tab_cnt[idx]);
		end
		@(negedge clk_in); // one idle cycle later
		check_bit("done", done, 1'b0);
		check_word("result", result, tab_res[idx]);
		if (tab_chk_cnt[idx]) begin
			check_word("shift_count", shift_count, tab_cnt[idx]);
		end
		if (test_errors == 0) begin
			$display("test %0d %s a=%h b=%h: ok", idx, op_name(tab_op[idx]),
				tab_a[idx], tab_b[idx]);
		end else begin
			$display("test %0d %s: %0d mismatches", idx, op_name(tab_op[idx]), test_errors);
			failed_tests++;
		end
		errors += test_errors;
	endtask

	initial begin
		reset_in     = 1'b1;
		start        = 1'b0;
		op           = sig_unit_pkg::OP_ADD;
		operand_a    = '0;
		operand_b    = '0;
		seed         = 32'ha31f153f;
		errors       = 0;
		failed_tests = 0;
		cur_test     = -1; // reset checks
		test_errors  = 0;
		fill_table();
		repeat (5) @(posedge clk_in);
		#2;
		reset_in = 1'b0;
		@(negedge clk_in);
		check_bit("done", done, 1'b0);
		check_word("result", result, '0);
		check_word("shift_count", shift_count, '0);
		@(negedge clk_in);
		check_word("result", result, '0);
		check_word("shift_count", shift_count, '0);
		errors += test_errors;
		for (int i = 0; i < NUM_TESTS; i++) begin
			run_entry(i);
		end
		$display("%0d tests run, %0d failed, %0d mismatches",
			NUM_TESTS, failed_tests, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/sig_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sig_unit_top (
	input  logic                    clk_in,
	input  logic                    reset_in,
	input  logic                    start,
	input  sig_unit_pkg::sig_op_t   op,
	input  sig_unit_pkg::sig_word_t operand_a,
	input  sig_unit_pkg::sig_word_t operand_b,
	output logic                    done,
	output sig_unit_pkg::sig_word_t result,
	output sig_unit_pkg::sig_word_t shift_count
);

	sig_unit_pkg::uaddr_t    uaddr;
	sig_unit_pkg::reg_sel_t  sel_a;
	sig_unit_pkg::reg_sel_t  sel_b;
	sig_unit_pkg::alu_op_t   alu_op;
	sig_unit_pkg::branch_t   branch;
	sig_unit_pkg::uaddr_t    target;
	sig_unit_pkg::sig_word_t read_a;
	sig_unit_pkg::sig_word_t read_b;
	sig_unit_pkg::sig_word_t alu_result;
	logic rom_we_r0;
	logic rom_we_r1;
	logic rom_shift_r0;
	logic last;
	logic zero;
	logic msb;
	logic we_r0;
	logic we_r1;
	logic shift_r0;

	sig_sequencer sig_sequencer_i (
		.clk_in(clk_in), .reset_in(reset_in), .start(start), .op(op),
		.branch(branch), .target(target), .last(last), .zero(zero), .msb(msb),
		.rom_we_r0(rom_we_r0), .rom_we_r1(rom_we_r1), .rom_shift_r0(rom_shift_r0),
		.uaddr(uaddr), .we_r0(we_r0), .we_r1(we_r1), .shift_r0(shift_r0), .done(done)
	);

	sig_microcode_rom sig_microcode_rom_i (
		.uaddr(uaddr), .sel_a(sel_a), .sel_b(sel_b), .alu_op(alu_op),
		.we_r0(rom_we_r0), .we_r1(rom_we_r1), .shift_r0(rom_shift_r0),
		.branch(branch), .target(target), .last(last)
	);

	// alu result feeds both write ports
	sig_register_file sig_register_file_i (
		.clk_in(clk_in), .reset_in(reset_in), .we_r0(we_r0), .we_r1(we_r1),
		.shift_r0(shift_r0), .write_r0(alu_result), .write_r1(alu_result),
		.sel_a(sel_a), .sel_b(sel_b), .read_a(read_a), .read_b(read_b)
	);

	sig_alu sig_alu_i (
		.alu_op(alu_op), .port_a(read_a), .port_b(read_b),
		.operand_a(operand_a), .operand_b(operand_b),
		.result(alu_result), .zero(zero), .msb(msb)
	);

	// idle and exit words select r0/r1
	assign result      = read_a;
	assign shift_count = read_b;

endmodule

`default_nettype wire

/* hw/sig_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sig_unit_settings.svh"

module sig_sequencer (
	input  logic                  clk_in,
	input  logic                  reset_in,
	input  logic                  start,
	input  sig_unit_pkg::sig_op_t op,
	input  sig_unit_pkg::branch_t branch,
	input  sig_unit_pkg::uaddr_t  target,
	input  logic                  last,
	input  logic                  zero,
	input  logic                  msb,
	input  logic                  rom_we_r0,
	input  logic                  rom_we_r1,
	input  logic                  rom_shift_r0,
	output sig_unit_pkg::uaddr_t  uaddr,
	output logic                  we_r0,
	output logic                  we_r1,
	output logic                  shift_r0,
	output logic                  done
);

	sig_unit_pkg::seq_state_t state;
	sig_unit_pkg::uaddr_t     upc;
	sig_unit_pkg::uaddr_t     upc_inc;
	sig_unit_pkg::uaddr_t     upc_next;
	sig_unit_pkg::uaddr_t     entry;
	logic                     run;

	assign run     = (state == sig_unit_pkg::SEQ_RUN);
	assign upc_inc = upc + 5'd1;

	// program entry for the requested op
	always_comb begin
		case (op)
			sig_unit_pkg::OP_ADD:  entry = `UADDR_ADD;
			sig_unit_pkg::OP_SUB:  entry = `UADDR_SUB;
			sig_unit_pkg::OP_NORM: entry = `UADDR_NORM;
			default:               entry = `UADDR_ROUND;
		endcase
	end

	// flags come from this cycle's alu result
	always_comb begin
		case (branch)
			sig_unit_pkg::BR_JUMP:    upc_next = target;
			sig_unit_pkg::BR_IF_ZERO: upc_next = zero ? target : upc_inc;
			sig_unit_pkg::BR_IF_MSB:  upc_next = msb ? target : upc_inc;
			default:                  upc_next = upc_inc;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= sig_unit_pkg::SEQ_IDLE;
			upc   <= '0;
		end else begin
			case (state)
				sig_unit_pkg::SEQ_IDLE: begin
					if (start) begin
						state <= sig_unit_pkg::SEQ_RUN;
						upc   <= entry;
					end
				end
				default: begin
					if (last) begin
						state <= sig_unit_pkg::SEQ_IDLE;
						upc   <= '0; // back to the idle word
					end else begin
						upc <= upc_next;
					end
				end
			endcase
		end
	end

	assign uaddr    = upc;
	assign we_r0    = run & rom_we_r0; // strobes quiet while idle
	assign we_r1    = run & rom_we_r1;
	assign shift_r0 = run & rom_shift_r0;
	assign done     = run & last;

endmodule

`default_nettype wire

/* hw/sig_microcode_rom.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sig_unit_settings.svh"

module sig_microcode_rom (
	input  sig_unit_pkg::uaddr_t   uaddr,
	output sig_unit_pkg::reg_sel_t sel_a,
	output sig_unit_pkg::reg_sel_t sel_b,
	output sig_unit_pkg::alu_op_t  alu_op,
	output logic                   we_r0,
	output logic                   we_r1,
	output logic                   shift_r0,
	output sig_unit_pkg::branch_t  branch,
	output sig_unit_pkg::uaddr_t   target,
	output logic                   last
);

	localparam sig_unit_pkg::uaddr_t UADDR_IDLE   = 5'd0;
	localparam sig_unit_pkg::uaddr_t UADDR_FINISH = 5'd1; // shared exit word
	localparam sig_unit_pkg::uaddr_t NORM_ZERO    = `UADDR_NORM + 5'd2;
	localparam sig_unit_pkg::uaddr_t NORM_TEST    = `UADDR_NORM + 5'd3;

	always_comb begin
		// defaults: read r0/r1, no writes, fall through
		sel_a    = sig_unit_pkg::REG_R0;
		sel_b    = sig_unit_pkg::REG_R1;
		alu_op   = sig_unit_pkg::ALU_PASS_A;
		we_r0    = 1'b0;
		we_r1    = 1'b0;
		shift_r0 = 1'b0;
		branch   = sig_unit_pkg::BR_NEXT;
		target   = UADDR_IDLE;
		last     = 1'b0;
		case (uaddr)
			UADDR_FINISH: last = 1'b1; // r0/r1 on the outputs
			`UADDR_ADD, `UADDR_SUB, `UADDR_ROUND, `UADDR_NORM: begin
				alu_op = sig_unit_pkg::ALU_EXT_A;
				we_r0  = 1'b1;
			end
			`UADDR_ADD + 5'd1, `UADDR_SUB + 5'd1: begin
				alu_op = sig_unit_pkg::ALU_EXT_B;
				we_r1  = 1'b1;
			end
			`UADDR_ADD + 5'd2: begin
				alu_op = sig_unit_pkg::ALU_ADD;
				we_r0  = 1'b1;
				branch = sig_unit_pkg::BR_JUMP;
				target = UADDR_FINISH;
			end
			`UADDR_SUB + 5'd2: begin
				alu_op = sig_unit_pkg::ALU_SUB;
				we_r0  = 1'b1;
				branch = sig_unit_pkg::BR_JUMP;
				target = UADDR_FINISH;
			end
			`UADDR_ROUND + 5'd1: begin
				sel_b  = sig_unit_pkg::REG_C3; // add one ulp
				alu_op = sig_unit_pkg::ALU_ADD;
				we_r0  = 1'b1;
				branch = sig_unit_pkg::BR_JUMP;
				target = UADDR_FINISH;
			end
			`UADDR_NORM + 5'd1: begin
				sel_a = sig_unit_pkg::REG_C0; // clear shift count
				we_r1 = 1'b1;
			end
			NORM_ZERO: begin
				branch = sig_unit_pkg::BR_IF_ZERO;
				target = UADDR_FINISH;
			end
			NORM_TEST: begin
				branch = sig_unit_pkg::BR_IF_MSB;
				target = UADDR_FINISH;
			end
			NORM_TEST + 5'd1: begin
				// count one and shift r0 in the same step
				sel_a    = sig_unit_pkg::REG_R1;
				sel_b    = sig_unit_pkg::REG_C1;
				alu_op   = sig_unit_pkg::ALU_ADD;
				we_r1    = 1'b1;
				shift_r0 = 1'b1;
				branch   = sig_unit_pkg::BR_JUMP;
				target   = NORM_TEST;
			end
			default: begin
				branch = sig_unit_pkg::BR_JUMP; // idle word and unused slots
				target = UADDR_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/sig_alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sig_unit_settings.svh"

module sig_alu (
	input  sig_unit_pkg::alu_op_t   alu_op,
	input  sig_unit_pkg::sig_word_t port_a,
	input  sig_unit_pkg::sig_word_t port_b,
	input  sig_unit_pkg::sig_word_t operand_a,
	input  sig_unit_pkg::sig_word_t operand_b,
	output sig_unit_pkg::sig_word_t result,
	output logic                    zero,
	output logic                    msb
);

	always_comb begin
		case (alu_op)
			sig_unit_pkg::ALU_PASS_A: begin
				result = port_a;
			end
			sig_unit_pkg::ALU_EXT_A: begin
				result = operand_a; // load from host
			end
			sig_unit_pkg::ALU_EXT_B: begin
				result = operand_b;
			end
			sig_unit_pkg::ALU_ADD: begin
				result = port_a + port_b; // carry out dropped
			end
			sig_unit_pkg::ALU_SUB: begin
				result = port_a - port_b; // wraps on borrow
			end
			default: begin
				result = port_a;
			end
		endcase
	end

	// branch flags for the sequencer
	assign zero = (result == '0);
	assign msb  = result[`SIG_WIDTH-1];

endmodule

`default_nettype wire

/* hw/sig_register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sig_unit_settings.svh"

module sig_register_file (
	input  logic                  clk_in,
	input  logic                  reset_in,
	input  logic                  we_r0,
	input  logic                  we_r1,
	input  logic                  shift_r0,
	input  sig_unit_pkg::sig_word_t write_r0,
	input  sig_unit_pkg::sig_word_t write_r1,
	input  sig_unit_pkg::reg_sel_t  sel_a,
	input  sig_unit_pkg::reg_sel_t  sel_b,
	output sig_unit_pkg::sig_word_t read_a,
	output sig_unit_pkg::sig_word_t read_b
);

	sig_unit_pkg::sig_word_t r0;
	sig_unit_pkg::sig_word_t r1;
	sig_unit_pkg::sig_word_t r0_written;
	sig_unit_pkg::sig_word_t r0_next;

	// one read port: general regs or a constant
	function automatic sig_unit_pkg::sig_word_t read_sel(
		input sig_unit_pkg::reg_sel_t  sel,
		input sig_unit_pkg::sig_word_t reg0,
		input sig_unit_pkg::sig_word_t reg1
	);
		case (sel)
			sig_unit_pkg::REG_R0: read_sel = reg0;
			sig_unit_pkg::REG_R1: read_sel = reg1;
			sig_unit_pkg::REG_C0: read_sel = `CONST0_VALUE;
			sig_unit_pkg::REG_C1: read_sel = `CONST1_VALUE;
			sig_unit_pkg::REG_C2: read_sel = `CONST2_VALUE;
			sig_unit_pkg::REG_C3: read_sel = `CONST3_VALUE;
			sig_unit_pkg::REG_C4: read_sel = `CONST4_VALUE;
			sig_unit_pkg::REG_C5: read_sel = `CONST5_VALUE;
			sig_unit_pkg::REG_C6: read_sel = `CONST6_VALUE;
			sig_unit_pkg::REG_C7: read_sel = `CONST7_VALUE;
			sig_unit_pkg::REG_C8: read_sel = `CONST8_VALUE;
			default:              read_sel = '0; // undefined code
		endcase
	endfunction

	always_comb begin
		read_a = read_sel(sel_a, r0, r1);
		read_b = read_sel(sel_b, r0, r1);
	end

	// write first, then shift the written value
	always_comb begin
		r0_written = we_r0 ? write_r0 : r0;
		r0_next    = shift_r0 ? (r0_written << 1) : r0_written;
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			r0 <= '0;
			r1 <= '0;
		end else begin
			r0 <= r0_next;
			if (we_r1) begin
				r1 <= write_r1;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/sig_unit_pkg.sv */
`default_nettype none

`include "sig_unit_settings.svh"

package sig_unit_pkg;

	typedef logic [`SIG_WIDTH-1:0]   sig_word_t;
	typedef logic [`SEL_WIDTH-1:0]   reg_sel_t;
	typedef logic [`UADDR_WIDTH-1:0] uaddr_t;
	typedef logic [1:0]              sig_op_t;
	typedef logic [2:0]              alu_op_t;
	typedef logic [1:0]              branch_t;

	// register file select codes, anything else reads zero
	localparam reg_sel_t REG_R0 = 4'd0;
	localparam reg_sel_t REG_R1 = 4'd1;
	localparam reg_sel_t REG_C0 = 4'd2;
	localparam reg_sel_t REG_C1 = 4'd3;
	localparam reg_sel_t REG_C2 = 4'd4;
	localparam reg_sel_t REG_C3 = 4'd5;
	localparam reg_sel_t REG_C4 = 4'd6;
	localparam reg_sel_t REG_C5 = 4'd7;
	localparam reg_sel_t REG_C6 = 4'd8;
	localparam reg_sel_t REG_C7 = 4'd9;
	localparam reg_sel_t REG_C8 = 4'd15;

	localparam sig_op_t OP_ADD   = 2'd0;
	localparam sig_op_t OP_SUB   = 2'd1;
	localparam sig_op_t OP_NORM  = 2'd2;
	localparam sig_op_t OP_ROUND = 2'd3;

	localparam alu_op_t ALU_PASS_A = 3'd0;
	localparam alu_op_t ALU_EXT_A  = 3'd1; // host operand a
	localparam alu_op_t ALU_EXT_B  = 3'd2; // host operand b
	localparam alu_op_t ALU_ADD    = 3'd3;
	localparam alu_op_t ALU_SUB    = 3'd4;

	localparam branch_t BR_NEXT    = 2'd0;
	localparam branch_t BR_JUMP    = 2'd1;
	localparam branch_t BR_IF_ZERO = 2'd2;
	localparam branch_t BR_IF_MSB  = 2'd3;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_t;

endpackage

`default_nettype wire

/* hw/sig_unit_settings.svh */
`ifndef SIG_UNIT_SETTINGS_SVH
`define SIG_UNIT_SETTINGS_SVH

// datapath widths
`define SIG_WIDTH   32
`define SEL_WIDTH   4
`define UADDR_WIDTH 5

// constant register contents, read-only in the register file
`define CONST0_VALUE 32'd0          // zero
`define CONST1_VALUE 32'd1          // one, normalize step count
`define CONST2_VALUE 32'd2
`define CONST3_VALUE 32'd128        // rounding ulp
`define CONST4_VALUE 32'd127        // exponent bias
`define CONST5_VALUE 32'd5          // div/sqrt normalization
`define CONST6_VALUE 32'd6          // div/sqrt normalization
`define CONST7_VALUE 32'h20000000   // nan significand
`define CONST8_VALUE 32'hffffffff   // all ones

// microprogram entry points
`define UADDR_ADD   5'd2
`define UADDR_SUB   5'd5
`define UADDR_ROUND 5'd8
`define UADDR_NORM  5'd10

`endif
